/* Makefile */
SIM       ?= verilator
SIM_FLAGS ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_nbf_host
FILELIST  ?= nbf_host.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the result"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* hdl/bedrock_fwd_if.sv */
`timescale 1ns/1ps
`include "nbf_defs.svh"

interface bedrock_fwd_if;

  // one beat per message, moves when v and ready are both high
  logic                          v;
  logic                          ready;
  bedrock_pkg::bedrock_fwd_hdr_s hdr;
  logic [`NBF_DATA_W-1:0]        data;

  modport sender (
    output v,
    output hdr,
    output data,
    input  ready
  );

  modport receiver (
    input  v,
    input  hdr,
    input  data,
    output ready
  );

endinterface

/* hdl/bedrock_pkg.sv */
`include "nbf_defs.svh"

package bedrock_pkg;

  // boot-file record kinds
  typedef enum logic [1:0] {
    NBF_WRITE  = 2'd0,
    NBF_READ   = 2'd1,
    NBF_FENCE  = 2'd2,
    NBF_FINISH = 2'd3
  } nbf_opcode_e;

  // single-beat memory message types
  typedef enum logic {
    MSG_WR = 1'b0,
    MSG_RD = 1'b1
  } bedrock_msg_e;

  // forward header, 17 bits
  typedef struct packed {
    bedrock_msg_e           msg_type;
    logic [`NBF_ADDR_W-1:0] addr;
  } bedrock_fwd_hdr_s;

  // reverse response, 33 bits
  typedef struct packed {
    bedrock_msg_e           msg_type;
    logic [`NBF_DATA_W-1:0] data;
  } bedrock_rev_s;

endpackage

/* hdl/fwd_fifo.sv */
`timescale 1ns/1ps
`include "nbf_defs.svh"

module fwd_fifo (
  input logic             clk_i,
  input logic             rst_n_i,
  bedrock_fwd_if.receiver enq,
  bedrock_fwd_if.sender   deq
);

  localparam int PTR_W = $clog2(`NBF_FIFO_DEPTH);
  localparam int CNT_W = $clog2(`NBF_FIFO_DEPTH + 1);

  bedrock_pkg::bedrock_fwd_hdr_s hdr_mem [`NBF_FIFO_DEPTH];
  logic [`NBF_DATA_W-1:0]        data_mem [`NBF_FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr_r;
  logic [PTR_W-1:0] rd_ptr_r;
  logic [CNT_W-1:0] count_r;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    next_ptr = (ptr == PTR_W'(`NBF_FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign enq.ready = (count_r != CNT_W'(`NBF_FIFO_DEPTH));
  assign deq.v     = (count_r != '0);
  assign deq.hdr   = hdr_mem[rd_ptr_r];
  assign deq.data  = data_mem[rd_ptr_r];

  assign push = enq.v & enq.ready;
  assign pop  = deq.v & deq.ready;

  // storage
  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      hdr_mem[wr_ptr_r]  <= enq.hdr;
      data_mem[wr_ptr_r] <= enq.data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_r <= next_ptr(wr_ptr_r);
      if (pop)
        rd_ptr_r <= next_ptr(rd_ptr_r);
      if (push && !pop)
        count_r <= count_r + 1'b1;
      else if (pop && !push)
        count_r <= count_r - 1'b1;
    end
  end

  // pointers meet only when the buffer is empty or full
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push |-> (wr_ptr_r != rd_ptr_r) || (count_r == '0));

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop |-> (wr_ptr_r != rd_ptr_r) || (count_r == CNT_W'(`NBF_FIFO_DEPTH)));

endmodule

/* hdl/host_dev.sv */
`timescale 1ns/1ps
`include "nbf_defs.svh"

module host_dev (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  bedrock_fwd_if.receiver           fwd,
  output logic                      rev_v_o,
  output bedrock_pkg::bedrock_rev_s rev_o,
  output logic                      putch_v_o,
  input  logic                      putch_ready_i,
  output logic [7:0]                putch_data_o,
  output logic                      finish_o,
  output logic [`NBF_TRACE_W-1:0]   trace_en_o
);

  logic                      is_wr;
  logic                      is_putch;
  logic                      consume;
  logic                      finish_r;
  logic [`NBF_TRACE_W-1:0]   trace_r;
  logic [`NBF_DATA_W-1:0]    rd_data;
  logic                      rev_v_r;
  bedrock_pkg::bedrock_rev_s rev_r;

  assign is_wr    = (fwd.hdr.msg_type == bedrock_pkg::MSG_WR);
  assign is_putch = is_wr && (fwd.hdr.addr == `HOST_PUTCH_ADDR);

  // putchar stalls on the outside sink, everything else drains at once
  assign putch_v_o    = fwd.v & is_putch;
  assign putch_data_o = fwd.data[7:0];
  assign fwd.ready    = is_putch ? putch_ready_i : 1'b1;
  assign consume      = fwd.v & fwd.ready;

  // readable registers
  always_comb
  begin
    case (fwd.hdr.addr)
      `HOST_FINISH_ADDR: rd_data = {{(`NBF_DATA_W-1){1'b0}}, finish_r};
      `HOST_TRACE_ADDR:  rd_data = {{(`NBF_DATA_W-`NBF_TRACE_W){1'b0}}, trace_r};
      default:           rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      finish_r <= 1'b0;
      trace_r  <= '0;
      rev_v_r  <= 1'b0;
    end
    else
    begin
      rev_v_r <= consume;
      // unmapped writes fall through and are only acked
      if (consume && is_wr)
      begin
        case (fwd.hdr.addr)
          `HOST_FINISH_ADDR: finish_r <= fwd.data[0];
          `HOST_TRACE_ADDR:  trace_r  <= fwd.data[`NBF_TRACE_W-1:0];
          default:           trace_r  <= trace_r;
        endcase
      end
    end
  end

  // response payload
  always_ff @(posedge clk_i)
  begin
    if (consume)
    begin
      rev_r.msg_type <= fwd.hdr.msg_type;
      rev_r.data     <= is_wr ? '0 : rd_data;
    end
  end

  assign rev_v_o    = rev_v_r;
  assign rev_o      = rev_r;
  assign finish_o   = finish_r;
  assign trace_en_o = trace_r;

  // one response per consumed message, next cycle, same type
  a_rev_follows: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    consume |=> rev_v_o && (rev_o.msg_type == $past(fwd.hdr.msg_type)));

endmodule

/* hdl/nbf_defs.svh */
`ifndef NBF_DEFS_SVH
`define NBF_DEFS_SVH

// datapath widths
`define NBF_ADDR_W 16
`define NBF_DATA_W 32

// number of trace-enable bits held by the host
`define NBF_TRACE_W 4

// forward FIFO entries
`define NBF_FIFO_DEPTH 4

// outstanding requests allowed at the loader
`define NBF_MAX_CREDITS 4

// host register map
`define HOST_PUTCH_ADDR 16'h1000
`define HOST_FINISH_ADDR 16'h2000
`define HOST_TRACE_ADDR 16'h3000

`endif

/* hdl/nbf_host_top.sv */
`timescale 1ns/1ps
`include "nbf_defs.svh"

module nbf_host_top (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     nbf_v_i,
  output logic                     nbf_ready_o,
  input  bedrock_pkg::nbf_opcode_e nbf_opcode_i,
  input  logic [`NBF_ADDR_W-1:0]   nbf_addr_i,
  input  logic [`NBF_DATA_W-1:0]   nbf_data_i,
  output logic                     putch_v_o,
  input  logic                     putch_ready_i,
  output logic [7:0]               putch_data_o,
  output logic                     rd_v_o,
  output logic [`NBF_DATA_W-1:0]   rd_data_o,
  output logic                     finish_o,
  output logic [`NBF_TRACE_W-1:0]  trace_en_o,
  output logic                     done_o
);

  // loader to FIFO, FIFO to host
  bedrock_fwd_if ldr_fwd ();
  bedrock_fwd_if host_fwd ();

  logic                      rev_v;
  bedrock_pkg::bedrock_rev_s rev;

  nbf_loader u_loader (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .nbf_v_i      (nbf_v_i),
    .nbf_ready_o  (nbf_ready_o),
    .nbf_opcode_i (nbf_opcode_i),
    .nbf_addr_i   (nbf_addr_i),
    .nbf_data_i   (nbf_data_i),
    .fwd          (ldr_fwd.sender),
    .rev_v_i      (rev_v),
    .rev_i        (rev),
    .rd_v_o       (rd_v_o),
    .rd_data_o    (rd_data_o),
    .done_o       (done_o)
  );

  fwd_fifo u_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .enq     (ldr_fwd.receiver),
    .deq     (host_fwd.sender)
  );

  host_dev u_host (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .fwd           (host_fwd.receiver),
    .rev_v_o       (rev_v),
    .rev_o         (rev),
    .putch_v_o     (putch_v_o),
    .putch_ready_i (putch_ready_i),
    .putch_data_o  (putch_data_o),
    .finish_o      (finish_o),
    .trace_en_o    (trace_en_o)
  );

endmodule

/* hdl/nbf_loader.sv */
`timescale 1ns/1ps
`include "nbf_defs.svh"

module nbf_loader (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      nbf_v_i,
  output logic                      nbf_ready_o,
  input  bedrock_pkg::nbf_opcode_e  nbf_opcode_i,
  input  logic [`NBF_ADDR_W-1:0]    nbf_addr_i,
  input  logic [`NBF_DATA_W-1:0]    nbf_data_i,
  bedrock_fwd_if.sender             fwd,
  input  logic                      rev_v_i,
  input  bedrock_pkg::bedrock_rev_s rev_i,
  output logic                      rd_v_o,
  output logic [`NBF_DATA_W-1:0]    rd_data_o,
  output logic                      done_o
);

  localparam int CRED_W = $clog2(`NBF_MAX_CREDITS + 1);

  logic [CRED_W-1:0] credits_r;
  logic              run_r;
  logic              done_r;
  logic              live;
  logic              is_req;
  logic              credit_ok;
  logic              drained;
  logic              issue;
  logic              finish_acc;

  // idle for one cycle after reset, and for good once finished
  assign live      = run_r & ~done_r;
  assign is_req    = (nbf_opcode_i == bedrock_pkg::NBF_WRITE) ||
                     (nbf_opcode_i == bedrock_pkg::NBF_READ);
  assign credit_ok = credits_r < CRED_W'(`NBF_MAX_CREDITS);
  assign drained   = (credits_r == '0);

  always_comb
  begin
    case (nbf_opcode_i)
      bedrock_pkg::NBF_WRITE,
      bedrock_pkg::NBF_READ:   nbf_ready_o = live & credit_ok & fwd.ready;
      bedrock_pkg::NBF_FENCE,
      bedrock_pkg::NBF_FINISH: nbf_ready_o = live & drained;
      default:                 nbf_ready_o = 1'b0;
    endcase
  end

  // requests go out in the cycle the record is taken
  assign fwd.v            = live & nbf_v_i & is_req & credit_ok;
  assign fwd.hdr.msg_type = (nbf_opcode_i == bedrock_pkg::NBF_READ) ?
                            bedrock_pkg::MSG_RD : bedrock_pkg::MSG_WR;
  assign fwd.hdr.addr     = nbf_addr_i;
  assign fwd.data         = nbf_data_i;

  assign issue      = fwd.v & fwd.ready;
  assign finish_acc = nbf_v_i & nbf_ready_o & (nbf_opcode_i == bedrock_pkg::NBF_FINISH);

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      credits_r <= '0;
      run_r     <= 1'b0;
      done_r    <= 1'b0;
    end
    else
    begin
      run_r  <= 1'b1;
      done_r <= done_r | finish_acc;
      case ({issue, rev_v_i})
        2'b10:   credits_r <= credits_r + 1'b1;
        2'b01:   credits_r <= credits_r - 1'b1;
        default: credits_r <= credits_r;
      endcase
    end
  end

  // read data is passed straight through as it lands
  assign rd_v_o    = rev_v_i & (rev_i.msg_type == bedrock_pkg::MSG_RD);
  assign rd_data_o = rev_i.data;
  assign done_o    = done_r;

  a_credit_limit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    credits_r <= CRED_W'(`NBF_MAX_CREDITS));

  // the host never answers a request that was not sent
  a_no_stray_rev: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    drained |-> !rev_v_i);

endmodule

/* nbf_host.f */
+incdir+hdl
hdl/bedrock_pkg.sv
hdl/bedrock_fwd_if.sv
hdl/nbf_loader.sv
hdl/fwd_fifo.sv
hdl/host_dev.sv
hdl/nbf_host_top.sv
test/tb_nbf_host.sv

/* test/tb_nbf_host.sv */
`timescale 1ns/1ps
`include "nbf_defs.svh"

module tb_nbf_host;

  localparam int PERIOD_NS   = 4;
  localparam int N_RECORDS   = 24;
  localparam int WATCHDOG_NS = (N_RECORDS * 40 + 200) * PERIOD_NS;

  logic                     clk_i;
  logic                     rst_n_i;
  logic                     nbf_v_i;
  logic                     nbf_ready_o;
  bedrock_pkg::nbf_opcode_e nbf_opcode_i;
  logic [`NBF_ADDR_W-1:0]   nbf_addr_i;
  logic [`NBF_DATA_W-1:0]   nbf_data_i;
  logic                     putch_v_o;
  logic                     putch_ready_i;
  logic [7:0]               putch_data_o;
  logic                     rd_v_o;
  logic [`NBF_DATA_W-1:0]   rd_data_o;
  logic                     finish_o;
  logic [`NBF_TRACE_W-1:0]  trace_en_o;
  logic                     done_o;

  // expected values filled by the stimulus
  logic [7:0]              sent_q[$];
  logic [`NBF_DATA_W-1:0]  rd_exp_q[$];
  logic [`NBF_TRACE_W-1:0] last_trace = '0;
  logic                    last_finish = 1'b0;
  int                      putch_idx = 0;
  int                      rd_idx = 0;
  logic                    acc_r = 1'b0;
  logic                    sync_chk = 1'b0;
  logic                    rand_ready = 1'b0;
  logic                    hold_ready = 1'b0;
  logic                    ready_next;
  logic [31:0]             rnd_state = 32'h500fa30e;
  int                      errors = 0;
  int                      errs_at_start = 0;
  int                      tests_run = 0;

  nbf_host_top dut (.*);

  always #(PERIOD_NS / 2) clk_i = ~clk_i;

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // putchar sink that is random or held
  always @(posedge clk_i)
  begin
    rnd_state = next_rand(rnd_state);
    ready_next = rand_ready ? rnd_state[0] : hold_ready;
    #1;
    putch_ready_i = ready_next;
  end

  // transfer tracking updated after the checks sample
  always @(posedge clk_i)
  begin
    acc_r <= nbf_v_i && nbf_ready_o;
    if (putch_v_o && putch_ready_i)
      putch_idx <= putch_idx + 1;
    if (rd_v_o)
      rd_idx <= rd_idx + 1;
  end

  task automatic flag_error(input string msg);
    errors++;
    $display("FAILED at %0t: %s", $time, msg);
  endtask

  a_reset_quiet: assert property (@(posedge clk_i) !rst_n_i |->
    !nbf_ready_o && !putch_v_o && !rd_v_o && !done_o && !finish_o && trace_en_o == '0)
    else flag_error("output active during reset");
  a_ready_after_reset: assert property (@(posedge clk_i) $rose(rst_n_i) |=> nbf_ready_o)
    else flag_error("nbf_ready_o low after reset");
  a_putch_order: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    putch_v_o && putch_ready_i |-> putch_idx < sent_q.size() && putch_data_o == sent_q[putch_idx])
    else flag_error("putchar byte wrong or extra");
  a_rd_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rd_v_o |-> rd_idx < rd_exp_q.size() && rd_data_o == rd_exp_q[rd_idx])
    else flag_error("read data mismatch");
  a_sync_regs: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    sync_chk |-> trace_en_o == last_trace && finish_o == last_finish &&
                 putch_idx == sent_q.size() && rd_idx == rd_exp_q.size())
    else flag_error("registers or counts wrong after fence");
  a_fence_holds: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    nbf_v_i && nbf_opcode_i == bedrock_pkg::NBF_FENCE && putch_v_o |-> !nbf_ready_o)
    else flag_error("fence taken with putchar pending");
  a_fence_drained: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    nbf_v_i && nbf_ready_o && nbf_opcode_i == bedrock_pkg::NBF_FENCE |->
    putch_idx == sent_q.size())
    else flag_error("fence taken before all characters left");
  a_finish_done: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    nbf_v_i && nbf_ready_o && nbf_opcode_i == bedrock_pkg::NBF_FINISH |=> done_o)
    else flag_error("done_o did not rise after finish");
  a_done_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i) done_o |=> done_o)
    else flag_error("done_o dropped");
  a_done_blocks: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    done_o |-> !nbf_ready_o)
    else flag_error("nbf_ready_o high after done");

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_i);
    #1;
  endtask

  task automatic send_record(input bedrock_pkg::nbf_opcode_e op,
                             input logic [`NBF_ADDR_W-1:0] addr,
                             input logic [`NBF_DATA_W-1:0] data);
    nbf_v_i      = 1'b1;
    nbf_opcode_i = op;
    nbf_addr_i   = addr;
    nbf_data_i   = data;
    do
      wait_cycles(1);
    while (!acc_r);
    nbf_v_i = 1'b0;
  endtask

  // fence drains all responses, then the register checks fire
  task automatic fence_and_check();
    send_record(bedrock_pkg::NBF_FENCE, '0, '0);
    sync_chk = 1'b1;
    wait_cycles(1);
    sync_chk = 1'b0;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    $display("test %0d %s: %0d errors", tests_run, name, errors - errs_at_start);
    errs_at_start = errors;
  endtask

  initial
  begin
    #(WATCHDOG_NS);
    $display("timeout: run did not complete within %0d ns", WATCHDOG_NS);
    $display("Result: FAILED");
    $finish;
  end

  initial
  begin
    logic [7:0]             ch;
    logic [`NBF_DATA_W-1:0] wr;
    clk_i         = 1'b0;
    rst_n_i       = 1'b0;
    nbf_v_i       = 1'b0;
    nbf_opcode_i  = bedrock_pkg::NBF_WRITE;
    nbf_addr_i    = '0;
    nbf_data_i    = '0;
    putch_ready_i = 1'b0;
    repeat (10) @(posedge clk_i);
    #1 rst_n_i = 1'b1;
    wait_cycles(2);
    end_test("reset");

    // characters under random back-pressure
    rand_ready = 1'b1;
    for (int i = 0; i < 12; i++)
    begin
      ch = 8'h41 + 8'(i);
      sent_q.push_back(ch);
      send_record(bedrock_pkg::NBF_WRITE, `HOST_PUTCH_ADDR, {24'ha5a5a5, ch});
    end
    fence_and_check();
    end_test("putchar");

    rand_ready = 1'b0;
    wr = 32'hdead_bee6;
    last_trace = wr[`NBF_TRACE_W-1:0];
    send_record(bedrock_pkg::NBF_WRITE, `HOST_TRACE_ADDR, wr);
    fence_and_check();
    rd_exp_q.push_back({{(`NBF_DATA_W-`NBF_TRACE_W){1'b0}}, last_trace});
    send_record(bedrock_pkg::NBF_READ, `HOST_TRACE_ADDR, '0);
    rd_exp_q.push_back('0);
    send_record(bedrock_pkg::NBF_READ, 16'h4440, '0);
    rd_exp_q.push_back({{(`NBF_DATA_W-1){1'b0}}, last_finish});
    send_record(bedrock_pkg::NBF_READ, `HOST_FINISH_ADDR, '0);
    fence_and_check();
    end_test("trace");

    // fence waits on a stalled character
    hold_ready = 1'b0;
    wait_cycles(2);
    sent_q.push_back(8'h5a);
    send_record(bedrock_pkg::NBF_WRITE, `HOST_PUTCH_ADDR, 32'h0000_005a);
    fork
      fence_and_check();
      begin
        repeat (8) @(posedge clk_i);
        #1 hold_ready = 1'b1;
      end
    join
    end_test("fence");

    last_finish = 1'b1;
    send_record(bedrock_pkg::NBF_WRITE, `HOST_FINISH_ADDR, 32'h1);
    fence_and_check();
    send_record(bedrock_pkg::NBF_FINISH, '0, '0);
    wait_cycles(10);
    end_test("finish");

    $display("tests run %0d, checks failed %0d", tests_run, errors);
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule
